/* clic_defs.svh */
`ifndef CLIC_DEFS_SVH
`define CLIC_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CLIC_NUM_IRQ 32
`define CLIC_CTL_BITS 8
`define CLIC_ID_W 12

// reported in the information word
`define CLIC_ARCH_VERSION 1
`define CLIC_IMPL_VERSION 2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CLIC_CFG_ADDR 0
`define CLIC_INFO_ADDR 4
// one word per interrupt from here on
`define CLIC_INT_BASE 4096

`endif

/* clic_pkg.sv */
package clic_pkg;

`include "clic_defs.svh"

  typedef logic [31:0] word_t;
  typedef logic [`CLIC_NUM_IRQ-1:0] irq_vec_t;
  // zero means no interrupt
  typedef logic [`CLIC_ID_W-1:0] irq_id_t;
  typedef logic [`CLIC_CTL_BITS-1:0] ctl_t;
  typedef ctl_t [`CLIC_NUM_IRQ-1:0] ctl_array_t;

  // bit 0 selects edge mode, bit 1 picks the falling edge
  typedef logic [1:0] trig_t;
  typedef trig_t [`CLIC_NUM_IRQ-1:0] trig_array_t;

  typedef struct packed {
    logic [1:0] nmbits;
    logic [3:0] nlbits;
    logic       nvbits;
  } clic_cfg_t;

  typedef struct packed {
    logic [1:0] mode;
    trig_t      trig;
    logic       shv;
  } clic_attr_t;

  // write when any strobe bit is set
  typedef struct packed {
    logic       valid;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
  } clic_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } clic_rsp_t;

  typedef struct packed {
    logic    meip;
    irq_id_t meid;
  } clic_irq_t;

endpackage

/* clic_regs.sv */
`timescale 1ns/1ps
`include "clic_defs.svh"

module clic_regs (
  input  logic                  clock,
  input  logic                  reset,
  input  clic_pkg::clic_req_t   req,
  input  clic_pkg::irq_vec_t    ip,
  output clic_pkg::clic_rsp_t   rsp,
  output clic_pkg::trig_array_t trig,
  output clic_pkg::irq_vec_t    ip_wr,
  output logic                  ip_wdata,
  output clic_pkg::irq_vec_t    ie,
  output clic_pkg::ctl_array_t  ctl,
  output logic [3:0]            nlbits
);

  localparam int IDX_W = $clog2(`CLIC_NUM_IRQ);
  localparam clic_pkg::word_t INT_END = `CLIC_INT_BASE + 4 * `CLIC_NUM_IRQ;

  // trigger count is fixed at zero
  localparam clic_pkg::word_t INFO_WORD = {
    1'b0,
    6'd0,
    4'(`CLIC_CTL_BITS),
    4'(`CLIC_ARCH_VERSION),
    4'(`CLIC_IMPL_VERSION),
    13'(`CLIC_NUM_IRQ)
  };

  clic_pkg::clic_cfg_t                     cfg;
  clic_pkg::clic_attr_t [`CLIC_NUM_IRQ-1:0] attr;

  logic             is_write;
  logic             cfg_hit;
  logic             info_hit;
  logic             int_hit;
  logic [IDX_W-1:0] idx;
  clic_pkg::word_t  int_word;
  clic_pkg::word_t  rdata_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    is_write = |req.wstrb;
    cfg_hit  = req.valid && (req.addr == `CLIC_CFG_ADDR);
    info_hit = req.valid && (req.addr == `CLIC_INFO_ADDR);
    int_hit  = req.valid && (req.addr >= `CLIC_INT_BASE) && (req.addr < INT_END);
    idx      = req.addr[IDX_W+1:2];
  end

  // read view of the addressed interrupt
  always_comb begin
    int_word        = '0;
    int_word[0]     = ip[idx];
    int_word[8]     = ie[idx];
    int_word[16]    = attr[idx].shv;
    int_word[18:17] = attr[idx].trig;
    int_word[23:22] = attr[idx].mode;
    int_word[31:24] = ctl[idx];
  end

  always_comb begin
    rdata_d = '0;
    if (!is_write) begin
      if (cfg_hit) begin
        rdata_d = {25'd0, cfg};
      end else if (info_hit) begin
        rdata_d = INFO_WORD;
      end else if (int_hit) begin
        rdata_d = int_word;
      end
    end
  end

  // pending lives in the gateway, only edge lines take a write
  always_comb begin
    ip_wr = '0;
    if (int_hit && req.wstrb[0] && attr[idx].trig[0]) begin
      ip_wr[idx] = 1'b1;
    end
  end

  assign ip_wdata = req.wdata[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registers and response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (reset) begin
      cfg  <= '0;
      ie   <= '0;
      attr <= '0;
      ctl  <= '0;
      rsp  <= '0;
    end else begin
      rsp.ready <= cfg_hit | info_hit | int_hit;
      rsp.rdata <= rdata_d;
      // all config fields sit in byte 0
      if (cfg_hit && req.wstrb[0]) begin
        cfg.nmbits <= req.wdata[6:5];
        cfg.nlbits <= req.wdata[4:1];
        cfg.nvbits <= req.wdata[0];
      end
      if (int_hit) begin
        if (req.wstrb[1]) begin
          ie[idx] <= req.wdata[8];
        end
        if (req.wstrb[2]) begin
          attr[idx].shv  <= req.wdata[16];
          attr[idx].trig <= req.wdata[18:17];
          attr[idx].mode <= req.wdata[23:22];
        end
        if (req.wstrb[3]) begin
          ctl[idx] <= req.wdata[31:24];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `CLIC_NUM_IRQ; i++) begin
      trig[i] = attr[i].trig;
    end
  end

  assign nlbits = cfg.nlbits;

endmodule

/* clic_gateway.sv */
`timescale 1ns/1ps
`include "clic_defs.svh"

module clic_gateway (
  input  logic                  clock,
  input  logic                  reset,
  input  clic_pkg::irq_vec_t    irq_lines,
  input  clic_pkg::trig_array_t trig,
  input  clic_pkg::irq_vec_t    ip_wr,
  input  logic                  ip_wdata,
  output clic_pkg::irq_vec_t    ip
);

  clic_pkg::irq_vec_t hist;
  clic_pkg::irq_vec_t rise;
  clic_pkg::irq_vec_t fall;
  clic_pkg::irq_vec_t edge_seen;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // edge detect against last cycle's inputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rise = irq_lines & ~hist;
    fall = hist & ~irq_lines;
    for (int i = 0; i < `CLIC_NUM_IRQ; i++) begin
      if (trig[i][1]) begin
        edge_seen[i] = fall[i];
      end else begin
        edge_seen[i] = rise[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      hist <= '0;
    end else begin
      hist <= irq_lines;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pending bits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clock) begin
    if (reset) begin
      ip <= '0;
    end else begin
      for (int i = 0; i < `CLIC_NUM_IRQ; i++) begin
        if (!trig[i][0]) begin
          // level mode tracks the pin
          ip[i] <= irq_lines[i];
        end else if (edge_seen[i]) begin
          // an edge beats a software clear in the same cycle
          ip[i] <= 1'b1;
        end else if (ip_wr[i]) begin
          ip[i] <= ip_wdata;
        end
      end
    end
  end

endmodule

/* clic_arbiter.sv */
`timescale 1ns/1ps
`include "clic_defs.svh"

module clic_arbiter (
  input  logic                 clock,
  input  logic                 reset,
  input  clic_pkg::irq_vec_t   ip,
  input  clic_pkg::irq_vec_t   ie,
  input  clic_pkg::ctl_array_t ctl,
  input  logic [3:0]           nlbits,
  output clic_pkg::clic_irq_t  irq
);

  localparam int NUM = `CLIC_NUM_IRQ;

  logic [3:0]           n_level;
  clic_pkg::ctl_t       lvl_mask;
  clic_pkg::ctl_array_t level_d;
  clic_pkg::ctl_array_t prio_d;
  clic_pkg::ctl_array_t level_q;
  clic_pkg::ctl_array_t prio_q;

  clic_pkg::ctl_t    best_level;
  clic_pkg::ctl_t    best_prio;
  clic_pkg::irq_id_t best_id;
  clic_pkg::irq_id_t win_id;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 1: mask and split into level / priority
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (nlbits > 4'(`CLIC_CTL_BITS)) begin
      n_level = 4'(`CLIC_CTL_BITS);
    end else begin
      n_level = nlbits;
    end
    // ones in the low bits that belong to priority
    lvl_mask = {`CLIC_CTL_BITS{1'b1}} >> n_level;
    level_d  = '0;
    prio_d   = '0;
    // line 0 never requests
    for (int i = 1; i < NUM; i++) begin
      if (ip[i] && ie[i]) begin
        level_d[i] = ctl[i] | lvl_mask;
        prio_d[i]  = ctl[i] | ~lvl_mask;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      level_q <= '0;
      prio_q  <= '0;
    end else begin
      level_q <= level_d;
      prio_q  <= prio_d;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage 2: linear max scan
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // strict compares keep the lowest id on a full tie
  always_comb begin
    best_level = '0;
    best_prio  = '0;
    best_id    = '0;
    for (int i = 1; i < NUM; i++) begin
      if ((level_q[i] > best_level) ||
          ((level_q[i] == best_level) && (prio_q[i] > best_prio))) begin
        best_level = level_q[i];
        best_prio  = prio_q[i];
        best_id    = clic_pkg::irq_id_t'(i);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      win_id <= '0;
    end else begin
      win_id <= best_id;
    end
  end

  // output stage
  always_ff @(posedge clock) begin
    if (reset) begin
      irq <= '0;
    end else begin
      irq.meip <= (win_id != '0);
      irq.meid <= win_id;
    end
  end

endmodule

/* clic_top.sv */
`timescale 1ns/1ps

module clic_top (
  input  logic                clock,
  input  logic                reset,
  input  clic_pkg::clic_req_t req,
  input  clic_pkg::irq_vec_t  irq_lines,
  output clic_pkg::clic_rsp_t rsp,
  output clic_pkg::clic_irq_t irq
);

  clic_pkg::trig_array_t trig;
  clic_pkg::irq_vec_t    ip_wr;
  logic                  ip_wdata;
  clic_pkg::irq_vec_t    ip;
  clic_pkg::irq_vec_t    ie;
  clic_pkg::ctl_array_t  ctl;
  logic [3:0]            nlbits;

  // bus side and register file
  clic_regs i_clic_regs (
    .clock    (clock),
    .reset    (reset),
    .req      (req),
    .ip       (ip),
    .rsp      (rsp),
    .trig     (trig),
    .ip_wr    (ip_wr),
    .ip_wdata (ip_wdata),
    .ie       (ie),
    .ctl      (ctl),
    .nlbits   (nlbits)
  );

  clic_gateway i_clic_gateway (
    .clock     (clock),
    .reset     (reset),
    .irq_lines (irq_lines),
    .trig      (trig),
    .ip_wr     (ip_wr),
    .ip_wdata  (ip_wdata),
    .ip        (ip)
  );

  // three cycles from ip to irq
  clic_arbiter i_clic_arbiter (
    .clock  (clock),
    .reset  (reset),
    .ip     (ip),
    .ie     (ie),
    .ctl    (ctl),
    .nlbits (nlbits),
    .irq    (irq)
  );

endmodule

/* clic_tb.sv */
`timescale 1ns/1ps
`include "clic_defs.svh"

module clic_tb;

  localparam int NUM = `CLIC_NUM_IRQ;
  localparam int BUS_TIMEOUT = 8;
  localparam int IRQ_TIMEOUT = 24;

  logic                clock;
  logic                reset;
  clic_pkg::clic_req_t req;
  clic_pkg::irq_vec_t  irq_lines;
  clic_pkg::clic_rsp_t rsp;
  clic_pkg::clic_irq_t irq;

  // reference model state
  clic_pkg::clic_cfg_t  m_cfg;
  clic_pkg::irq_vec_t   m_ie;
  clic_pkg::irq_vec_t   m_ip;
  clic_pkg::irq_vec_t   m_hist;
  clic_pkg::ctl_array_t m_ctl;
  clic_pkg::clic_attr_t m_attr [NUM];

  clic_pkg::word_t rng_state;
  int err_count;
  int errs_at_start;
  int tests_passed;
  int tests_failed;

  clic_top i_clic_top (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .irq_lines (irq_lines),
    .rsp       (rsp),
    .irq       (irq)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    #1000000;
    $display("ERROR: global simulation timeout reached");
    $display("SIMULATION FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic clic_pkg::word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic clic_pkg::word_t int_addr(int n);
    return `CLIC_INT_BASE + 4 * n;
  endfunction

  function automatic void model_reset();
    m_cfg  = '0;
    m_ie   = '0;
    m_ip   = '0;
    m_hist = '0;
    m_ctl  = '0;
    for (int i = 0; i < NUM; i++) begin
      m_attr[i] = '0;
    end
  endfunction

  function automatic void model_write(clic_pkg::word_t addr, clic_pkg::word_t wdata,
                                      logic [3:0] wstrb);
    int n;
    if (addr == `CLIC_CFG_ADDR && wstrb[0]) begin
      m_cfg.nvbits = wdata[0];
      m_cfg.nlbits = wdata[4:1];
      m_cfg.nmbits = wdata[6:5];
    end else if (addr >= `CLIC_INT_BASE && addr < `CLIC_INT_BASE + 4 * NUM) begin
      n = int'((addr - `CLIC_INT_BASE) >> 2);
      // pending load follows the mode held before this write
      if (wstrb[0] && m_attr[n].trig[0]) m_ip[n] = wdata[0];
      if (wstrb[1]) m_ie[n] = wdata[8];
      if (wstrb[2]) begin
        m_attr[n].shv  = wdata[16];
        m_attr[n].trig = wdata[18:17];
        m_attr[n].mode = wdata[23:22];
      end
      if (wstrb[3]) m_ctl[n] = wdata[31:24];
      if (!m_attr[n].trig[0]) m_ip[n] = m_hist[n];
    end
  endfunction

  function automatic clic_pkg::word_t expected_word(int n);
    clic_pkg::word_t w;
    w        = '0;
    w[0]     = m_ip[n];
    w[8]     = m_ie[n];
    w[16]    = m_attr[n].shv;
    w[18:17] = m_attr[n].trig;
    w[23:22] = m_attr[n].mode;
    w[31:24] = m_ctl[n];
    return w;
  endfunction

  function automatic clic_pkg::irq_id_t expected_winner();
    int n;
    clic_pkg::ctl_t low_ones;
    clic_pkg::ctl_t lvl;
    clic_pkg::ctl_t pri;
    clic_pkg::ctl_t best_lvl;
    clic_pkg::ctl_t best_pri;
    clic_pkg::irq_id_t best;
    n = int'(m_cfg.nlbits);
    if (n > `CLIC_CTL_BITS) n = `CLIC_CTL_BITS;
    low_ones = clic_pkg::ctl_t'((1 << (`CLIC_CTL_BITS - n)) - 1);
    best_lvl = '0;
    best_pri = '0;
    best     = '0;
    for (int i = 1; i < NUM; i++) begin
      if (m_ip[i] && m_ie[i]) begin
        lvl = m_ctl[i] | low_ones;
        pri = m_ctl[i] | ~low_ones;
        if (lvl > best_lvl || (lvl == best_lvl && pri > best_pri)) begin
          best_lvl = lvl;
          best_pri = pri;
          best     = clic_pkg::irq_id_t'(i);
        end
      end
    end
    return best;
  endfunction

  task automatic check_value(string name, clic_pkg::word_t got, clic_pkg::word_t exp);
    assert (got == exp) else begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_true(bit cond, string what);
    assert (cond) else begin
      $display("ERROR: %s", what);
      err_count++;
    end
  endtask

  task automatic finish_test(int num, string name);
    if (err_count == errs_at_start) begin
      tests_passed++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lat comes back zero when no ready shows up
  task automatic bus_access(input clic_pkg::word_t addr, input clic_pkg::word_t wdata,
                            input logic [3:0] wstrb, output clic_pkg::word_t rdata,
                            output int lat);
    clic_pkg::clic_req_t r;
    r.valid = 1'b1;
    r.addr  = addr;
    r.wdata = wdata;
    r.wstrb = wstrb;
    @(posedge clock);
    req <= r;
    @(posedge clock);
    req   <= '0;
    rdata = '0;
    lat   = 0;
    for (int c = 1; c <= BUS_TIMEOUT && lat == 0; c++) begin
      @(negedge clock);
      if (rsp.ready) begin
        lat   = c;
        rdata = rsp.rdata;
      end
    end
  endtask

  task automatic do_write(clic_pkg::word_t addr, clic_pkg::word_t wdata, logic [3:0] wstrb);
    clic_pkg::word_t rd;
    int lat;
    model_write(addr, wdata, wstrb);
    bus_access(addr, wdata, wstrb, rd, lat);
    check_true(lat == 1, $sformatf("write to 0x%h got no ready one cycle later", addr));
    check_value("rdata", rd, '0);
    @(negedge clock);
    check_true(!rsp.ready, $sformatf("ready for write to 0x%h stayed high", addr));
  endtask

  task automatic do_read(clic_pkg::word_t addr, clic_pkg::word_t exp, string name);
    clic_pkg::word_t rd;
    int lat;
    bus_access(addr, '0, 4'b0000, rd, lat);
    check_true(lat == 1, $sformatf("read of 0x%h got no ready one cycle later", addr));
    check_value(name, rd, exp);
    @(negedge clock);
    check_true(!rsp.ready, $sformatf("ready for read of 0x%h stayed high", addr));
  endtask

  task automatic read_all_words();
    for (int n = 0; n < NUM; n++) begin
      do_read(int_addr(n), expected_word(n), $sformatf("rdata[%0d]", n));
    end
  endtask

  task automatic clear_int_words();
    for (int n = 0; n < NUM; n++) begin
      do_write(int_addr(n), '0, 4'b1111);
    end
  endtask

  // the gateway compares against the last driven value
  task automatic set_lines(clic_pkg::irq_vec_t v);
    @(posedge clock);
    irq_lines <= v;
    for (int i = 0; i < NUM; i++) begin
      if (!m_attr[i].trig[0]) begin
        m_ip[i] = v[i];
      end else if (m_attr[i].trig[1] ? (m_hist[i] && !v[i]) : (!m_hist[i] && v[i])) begin
        m_ip[i] = 1'b1;
      end
    end
    m_hist = v;
  endtask

  // irq must match the model for a few cycles in a row
  task automatic wait_irq();
    clic_pkg::irq_id_t exp;
    int stable;
    exp    = expected_winner();
    stable = 0;
    for (int c = 0; c < IRQ_TIMEOUT && stable < 4; c++) begin
      @(negedge clock);
      if (irq.meid == exp && irq.meip == (exp != '0)) stable++;
      else stable = 0;
    end
    check_true(stable >= 4, "irq did not settle before the timeout");
    check_value("meid", 32'(irq.meid), 32'(exp));
    check_value("meip", 32'(irq.meip), 32'(exp != '0));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    clic_pkg::word_t r;
    clic_pkg::word_t wd;
    clic_pkg::word_t rd;
    clic_pkg::word_t addr;
    int n;
    int lat;
    rng_state     = 32'd67664;
    err_count     = 0;
    errs_at_start = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    reset         = 1'b1;
    req           = '0;
    irq_lines     = '0;
    model_reset();
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    for (int k = 0; k < 80; k++) begin
      r    = next_rand();
      n    = int'(r[12:8]);
      addr = r[0] ? `CLIC_CFG_ADDR : int_addr(n);
      if (r[1]) begin
        do_write(addr, next_rand(), (r[7:4] == 4'd0) ? 4'b0001 : r[7:4]);
      end else begin
        do_read(addr, r[0] ? {25'd0, m_cfg} : expected_word(n), "rdata");
      end
    end
    do_read(`CLIC_INFO_ADDR, `CLIC_NUM_IRQ | (`CLIC_IMPL_VERSION << 13) |
            (`CLIC_ARCH_VERSION << 17) | (`CLIC_CTL_BITS << 21), "info rdata");
    bus_access(32'h8, '0, 4'b0000, rd, lat);
    check_true(lat == 0, "read of unmapped address 0x8 got a ready");
    bus_access(int_addr(NUM), 32'hffff_ffff, 4'b1111, rd, lat);
    check_true(lat == 0, "write past the last interrupt word got a ready");
    do_read(`CLIC_CFG_ADDR, {25'd0, m_cfg}, "cfg rdata");
    read_all_words();
    finish_test(1, "register access");

    clear_int_words();
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < NUM; i++) do_write(int_addr(i), next_rand(), 4'b0010);
      set_lines(next_rand());
      read_all_words();
    end
    finish_test(2, "level triggering");

    clear_int_words();
    set_lines('0);
    for (int i = 0; i < NUM; i++) begin
      wd     = next_rand();
      wd[17] = 1'b1;
      do_write(int_addr(i), wd, 4'b0100);
    end
    for (int k = 0; k < 10; k++) begin
      set_lines(next_rand());
      set_lines(next_rand());
      read_all_words();
    end
    for (int i = 0; i < NUM; i++) do_write(int_addr(i), '0, 4'b0001);
    read_all_words();
    // even lines back to level, then try to set every pending bit
    for (int i = 0; i < NUM; i += 2) do_write(int_addr(i), '0, 4'b0100);
    for (int i = 0; i < NUM; i++) do_write(int_addr(i), 32'h1, 4'b0001);
    read_all_words();
    finish_test(3, "edge triggering");

    clear_int_words();
    for (int k = 0; k < 30; k++) begin
      for (int i = 0; i < NUM; i++) begin
        wd = next_rand();
        // few distinct control values so ties are common
        if (k[0]) wd = wd & 32'hc3ff_ffff;
        do_write(int_addr(i), wd, 4'b1010);
      end
      do_write(`CLIC_CFG_ADDR, next_rand(), 4'b0001);
      set_lines(next_rand());
      wait_irq();
    end
    finish_test(4, "arbitration");

    for (int i = 0; i < NUM; i++) do_write(int_addr(i), '0, 4'b0010);
    set_lines('1);
    wait_irq();
    check_value("meid", 32'(irq.meid), '0);
    do_write(int_addr(0), 32'hff00_0100, 4'b1010);
    set_lines(32'h1);
    wait_irq();
    check_value("meip", 32'(irq.meip), '0);
    check_value("meid", 32'(irq.meid), '0);
    finish_test(5, "no request");

    do_write(int_addr(5), 32'h8000_0100, 4'b1010);
    set_lines('1);
    wait_irq();
    @(posedge clock);
    reset     <= 1'b1;
    irq_lines <= '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    model_reset();
    @(negedge clock);
    check_value("ready", 32'(rsp.ready), '0);
    check_value("meip", 32'(irq.meip), '0);
    check_value("meid", 32'(irq.meid), '0);
    read_all_words();
    do_read(`CLIC_CFG_ADDR, '0, "cfg rdata");
    finish_test(6, "reset state");

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+.
clic_pkg.sv
clic_regs.sv
clic_gateway.sv
clic_arbiter.sv
clic_top.sv
clic_tb.sv

/* run.sh */
#!/bin/bash
# build the clic testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module clic_tb -f list.f -o clic_sim \
  > build.log 2>&1 \
  && ./obj_dir/clic_sim > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
